//--- flist.f
verilog/cpu_pkg.sv
verilog/instr_fetch.sv
verilog/decode_regfile.sv
verilog/alu_execute.sv
verilog/data_memory.sv
verilog/cpu_control.sv
verilog/cpu_top.sv
sim/cpu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cpu_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/cpu_stim.txt
// @00 program words, one instruction per line, ends with halt
// @40 write-back records: rd, data, ccr flags (c n z); @ff record count
@00
8134 // ldm r1, 34
8212 // ldm r2, 12
0B28 // add r3, r1, r2
1444 // sub r4, r2, r1
1D84 // and r5, r4, r1
2688 // or  r6, r4, r2
2FD8 // xor r7, r6, r6
902C // st  [r1], r3
8D20 // ld  r5, [r1]
0000 // nop
0890 // add r0, r4, r4
1124 // sub r1, r1, r1
F800 // halt
@40
1 0034 0
2 0012 0
3 0046 0
4 FFDE 6
5 0014 0
6 FFDE 2
7 0000 1
5 0046 1
0 FFBC 6
1 0000 1
@ff
000a

//--- sim/cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_tb;

  localparam int clk_period  = 40;
  localparam int rst_cycles  = 8;
  localparam int stim_depth  = 256;
  localparam int prog_max    = 64;    // program area 00..3f
  localparam int rec_base    = 'h40;
  localparam int rec_max     = 63;
  localparam int count_addr  = 'hff;
  localparam int tail_cycles = 20;    // watch for stray write backs after halt
  localparam int rand_ops    = 24;

  logic                             clk;
  logic                             rst;
  logic                             start;
  logic                             prog_we;
  logic [cpu_pkg::imem_addr_w-1:0]  prog_addr;
  logic [cpu_pkg::data_w-1:0]       prog_data;
  logic                             wb_valid;
  logic [cpu_pkg::reg_addr_w-1:0]   wb_addr;
  logic [cpu_pkg::data_w-1:0]       wb_data;
  logic [cpu_pkg::ccr_w-1:0]        ccr;
  logic                             halted;

  logic [cpu_pkg::data_w-1:0]       stim_mem [stim_depth];
  logic [cpu_pkg::data_w-1:0]       prog_q [$];  // both programs back to back
  logic [cpu_pkg::reg_addr_w-1:0]   exp_addr_q [$];
  logic [cpu_pkg::data_w-1:0]       exp_data_q [$];
  logic [cpu_pkg::ccr_w-1:0]        exp_ccr_q [$];
  int                               errors;
  int                               checks;
  int                               seed;
  int                               wd_cycles;
  int                               dir_p_hi;
  int                               dir_e_hi;
  int                               rnd_p_lo;
  int                               rnd_e_lo;

  cpu_top cpu_top_inst (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .wb_valid  (wb_valid),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data),
    .ccr       (ccr),
    .halted    (halted)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [cpu_pkg::data_w-1:0] reg_word(input cpu_pkg::opcode_t op,
      input logic [2:0] rd, input logic [2:0] rs, input logic [2:0] rt);
    return {op, rd, rs, rt, 2'b00};
  endfunction

  function automatic logic [cpu_pkg::data_w-1:0] imm_word(input cpu_pkg::opcode_t op,
      input logic [2:0] rd, input logic [7:0] imm8);
    return {op, rd, imm8};
  endfunction

  // ALU ops, ldm and ld report a write back
  function automatic logic writes_back(input logic [cpu_pkg::data_w-1:0] word);
    case (word[cpu_pkg::op_lsb +: cpu_pkg::op_w])
      cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and, cpu_pkg::op_or,
      cpu_pkg::op_xor, cpu_pkg::op_ldm, cpu_pkg::op_ld:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [cpu_pkg::data_w-1:0] exp,
      input logic [cpu_pkg::data_w-1:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("ERR t=%0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  task automatic check_idle();
    check_value("wb_valid", '0, 16'(wb_valid));
    check_value("halted", '0, 16'(halted));
  endtask

  task automatic add_record(input logic [2:0] rd, input logic [cpu_pkg::data_w-1:0] data,
      input logic [cpu_pkg::ccr_w-1:0] flags);
    exp_addr_q.push_back(rd);
    exp_data_q.push_back(data);
    exp_ccr_q.push_back(flags);
  endtask

  task automatic load_stim();
    int n_prog;
    int n_rec;
    int n_wb;
    n_prog = 0;
    n_wb   = 0;
    while (n_prog < prog_max &&
           stim_mem[n_prog][cpu_pkg::op_lsb +: cpu_pkg::op_w] !== cpu_pkg::op_halt)
    begin
      prog_q.push_back(stim_mem[n_prog]);
      if (writes_back(stim_mem[n_prog]))
        n_wb++;
      n_prog++;
    end
    assert (n_prog < prog_max)
    else
    begin
      errors++;
      $display("no halt instruction found in the program area of the stim file");
    end
    prog_q.push_back(imm_word(cpu_pkg::op_halt, '0, '0));
    n_rec = int'(stim_mem[count_addr]);
    assert (n_rec == n_wb && n_rec <= rec_max)
    else
    begin
      errors++;
      $display("stim record count %0d does not fit the %0d write backs", n_rec, n_wb);
    end
    for (int i = 0; i < n_rec && i < rec_max; i++)
      add_record(stim_mem[rec_base + 3 * i][cpu_pkg::reg_addr_w-1:0],
                 stim_mem[rec_base + 3 * i + 1],
                 stim_mem[rec_base + 3 * i + 2][cpu_pkg::ccr_w-1:0]);
  endtask

  // random operands, expected write backs from the instruction rules
  task automatic build_random_program();
    logic [cpu_pkg::data_w-1:0] regs [cpu_pkg::num_regs];
    logic [cpu_pkg::data_w-1:0] res;
    logic [cpu_pkg::ccr_w-1:0]  flags;
    logic                       carry;
    logic [31:0]                r;
    logic [2:0]                 rd;
    logic [2:0]                 rs;
    logic [2:0]                 rt;
    cpu_pkg::opcode_t           op;
    flags = '0;  // ccr after reset
    for (int i = 0; i < cpu_pkg::num_regs; i++)
    begin
      r       = $random(seed);
      rd      = 3'(i);
      regs[i] = {8'h00, r[7:0]};
      prog_q.push_back(imm_word(cpu_pkg::op_ldm, rd, r[7:0]));
      add_record(rd, regs[i], flags);
    end
    for (int k = 0; k < rand_ops; k++)
    begin
      r  = $random(seed);
      rd = r[5:3];
      rs = r[8:6];
      rt = r[11:9];
      case (r[2:0])
        3'd5:
        begin
          regs[rd] = {8'h00, r[19:12]};
          prog_q.push_back(imm_word(cpu_pkg::op_ldm, rd, r[19:12]));
          add_record(rd, regs[rd], flags);
        end
        3'd6:
        begin
          // store, then load the same address back into rd
          prog_q.push_back(reg_word(cpu_pkg::op_st, 3'd0, rs, rt));
          prog_q.push_back(reg_word(cpu_pkg::op_ld, rd, rs, 3'd0));
          regs[rd] = regs[rt];
          add_record(rd, regs[rd], flags);
        end
        default:
        begin
          case (r[2:0])
            3'd1:    op = cpu_pkg::op_sub;
            3'd2:    op = cpu_pkg::op_and;
            3'd3:    op = cpu_pkg::op_or;
            3'd4:    op = cpu_pkg::op_xor;
            default: op = cpu_pkg::op_add;
          endcase
          carry = 1'b0;
          case (op)
            cpu_pkg::op_add:
              {carry, res} = {1'b0, regs[rs]} + {1'b0, regs[rt]};
            cpu_pkg::op_sub:
            begin
              res   = regs[rs] - regs[rt];
              carry = regs[rs] < regs[rt];  // borrow
            end
            cpu_pkg::op_and:
              res = regs[rs] & regs[rt];
            cpu_pkg::op_or:
              res = regs[rs] | regs[rt];
            default:
              res = regs[rs] ^ regs[rt];
          endcase
          regs[rd] = res;
          flags[cpu_pkg::ccr_z] = (res == '0);
          flags[cpu_pkg::ccr_n] = res[cpu_pkg::data_w-1];
          flags[cpu_pkg::ccr_c] = carry;
          prog_q.push_back(reg_word(op, rd, rs, rt));
          add_record(rd, res, flags);
        end
      endcase
    end
    prog_q.push_back(imm_word(cpu_pkg::op_halt, '0, '0));
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst     <= 1'b1;
    start   <= 1'b0;
    prog_we <= 1'b0;
    repeat (rst_cycles)
    begin
      @(negedge clk);
      check_idle();
      @(posedge clk);
    end
    rst <= 1'b0;
  endtask

  task automatic run_program(input int p_lo, input int p_hi, input int e_lo, input int e_hi);
    int   halt_idx;
    int   last_n;
    int   k;
    int   rec;
    logic exp_wb;
    halt_idx = p_hi - p_lo - 1;  // halt is the last word
    last_n   = 6 + 5 * halt_idx + tail_cycles;
    rec      = e_lo;
    apply_reset();
    for (int i = p_lo; i < p_hi; i++)
    begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= (cpu_pkg::imem_addr_w)'(i - p_lo);
      prog_data <= prog_q[i];
      @(negedge clk);
      check_idle();
    end
    @(posedge clk);
    prog_we <= 1'b0;
    start   <= 1'b1;
    @(negedge clk);
    check_idle();
    @(posedge clk);
    start <= 1'b0;  // this edge samples the pulse
    for (int n = 1; n <= last_n; n++)
    begin
      @(negedge clk);
      k      = (n - 6) / 5;
      exp_wb = 1'b0;
      if (n >= 6 && (n - 6) % 5 == 0 && k < halt_idx)
        exp_wb = writes_back(prog_q[p_lo + k]);  // one instruction every 5 cycles
      check_value("wb_valid", 16'(exp_wb), 16'(wb_valid));
      check_value("halted", 16'(n >= 6 + 5 * halt_idx), 16'(halted));
      if (exp_wb)
      begin
        if (rec < e_hi)
        begin
          check_value("wb_addr", 16'(exp_addr_q[rec]), 16'(wb_addr));
          check_value("wb_data", exp_data_q[rec], wb_data);
          check_value("ccr", 16'(exp_ccr_q[rec]), 16'(ccr));
        end
        rec++;
      end
    end
    assert (rec == e_hi)
    else
    begin
      errors++;
      $display("program produced %0d write backs but %0d were expected", rec - e_lo,
               e_hi - e_lo);
    end
  endtask

  initial
  begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles with %0d errors, run did not complete",
             wd_cycles, errors);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    clk       = 1'b0;
    rst       = 1'b1;
    start     = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    errors    = 0;
    checks    = 0;
    seed      = 32'hc0d9;
    wd_cycles = 0;
    $readmemh("sim/cpu_stim.txt", stim_mem);
    load_stim();
    dir_p_hi = prog_q.size();
    dir_e_hi = exp_data_q.size();
    rnd_p_lo = dir_p_hi;
    rnd_e_lo = dir_e_hi;
    build_random_program();
    wd_cycles = prog_q.size() * 5 + 200;
    run_program(0, dir_p_hi, 0, dir_e_hi);
    run_program(rnd_p_lo, prog_q.size(), rnd_e_lo, exp_data_q.size());
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               start,
  input  wire                               prog_we,
  input  wire  [cpu_pkg::imem_addr_w-1:0]   prog_addr,
  input  wire  [cpu_pkg::data_w-1:0]        prog_data,
  output logic                              wb_valid,
  output logic [cpu_pkg::reg_addr_w-1:0]    wb_addr,
  output logic [cpu_pkg::data_w-1:0]        wb_data,
  output logic [cpu_pkg::ccr_w-1:0]         ccr,
  output logic                              halted
);

  logic                             fetch_en;
  logic                             exec_en;
  logic                             mem_en;
  logic [cpu_pkg::imem_addr_w-1:0]  pc;
  logic [cpu_pkg::data_w-1:0]       instr;
  logic [cpu_pkg::data_w-1:0]       ifid_instr;

  // decoder outputs
  logic [cpu_pkg::data_w-1:0]       op_a;
  logic [cpu_pkg::data_w-1:0]       op_b;
  logic [cpu_pkg::data_w-1:0]       imm;
  logic [cpu_pkg::reg_addr_w-1:0]   dest;
  cpu_pkg::opcode_t                 alu_op;
  logic                             use_imm;
  logic                             mem_rd;
  logic                             mem_wr;
  logic                             reg_wr;
  logic                             is_halt;

  logic [cpu_pkg::data_w-1:0]       idex_op_a;
  logic [cpu_pkg::data_w-1:0]       idex_op_b;
  logic [cpu_pkg::data_w-1:0]       idex_imm;
  cpu_pkg::opcode_t                 idex_alu_op;
  logic                             idex_use_imm;
  logic [cpu_pkg::data_w-1:0]       result;
  logic [cpu_pkg::dmem_addr_w-1:0]  mem_addr;
  logic [cpu_pkg::dmem_addr_w-1:0]  exmem_addr;
  logic [cpu_pkg::data_w-1:0]       exmem_wdata;
  logic                             exmem_mem_rd;
  logic                             exmem_mem_wr;
  logic [cpu_pkg::data_w-1:0]       rdata;

  cpu_control cpu_control_inst (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .pc           (pc),
    .instr        (instr),
    .op_a         (op_a),
    .op_b         (op_b),
    .imm          (imm),
    .dest         (dest),
    .alu_op       (alu_op),
    .use_imm      (use_imm),
    .mem_rd       (mem_rd),
    .mem_wr       (mem_wr),
    .reg_wr       (reg_wr),
    .is_halt      (is_halt),
    .result       (result),
    .mem_addr     (mem_addr),
    .rdata        (rdata),
    .fetch_en     (fetch_en),
    .exec_en      (exec_en),
    .mem_en       (mem_en),
    .ifid_instr   (ifid_instr),
    .idex_op_a    (idex_op_a),
    .idex_op_b    (idex_op_b),
    .idex_imm     (idex_imm),
    .idex_alu_op  (idex_alu_op),
    .idex_use_imm (idex_use_imm),
    .exmem_addr   (exmem_addr),
    .exmem_wdata  (exmem_wdata),
    .exmem_mem_rd (exmem_mem_rd),
    .exmem_mem_wr (exmem_mem_wr),
    .wb_valid     (wb_valid),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data),
    .halted       (halted)
  );

  instr_fetch instr_fetch_inst (
    .clk       (clk),
    .rst       (rst),
    .fetch_en  (fetch_en),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .instr     (instr),
    .pc        (pc)
  );

  decode_regfile decode_regfile_inst (
    .clk     (clk),
    .rst     (rst),
    .instr   (ifid_instr),  // held fetch/decode copy
    .wb_we   (wb_valid),
    .wb_addr (wb_addr),
    .wb_data (wb_data),
    .op_a    (op_a),
    .op_b    (op_b),
    .imm     (imm),
    .dest    (dest),
    .alu_op  (alu_op),
    .use_imm (use_imm),
    .mem_rd  (mem_rd),
    .mem_wr  (mem_wr),
    .reg_wr  (reg_wr),
    .is_halt (is_halt)
  );

  alu_execute alu_execute_inst (
    .clk      (clk),
    .rst      (rst),
    .exec_en  (exec_en),
    .op_a     (idex_op_a),
    .op_b     (idex_op_b),
    .imm      (idex_imm),
    .alu_op   (idex_alu_op),
    .use_imm  (idex_use_imm),
    .result   (result),
    .mem_addr (mem_addr),
    .ccr      (ccr)
  );

  data_memory data_memory_inst (
    .clk    (clk),
    .mem_en (mem_en),
    .mem_rd (exmem_mem_rd),
    .mem_wr (exmem_mem_wr),
    .addr   (exmem_addr),
    .wdata  (exmem_wdata),
    .rdata  (rdata)
  );

endmodule

`default_nettype wire

//--- verilog/cpu_control.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_control (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               start,
  input  wire  [cpu_pkg::imem_addr_w-1:0]   pc,
  input  wire  [cpu_pkg::data_w-1:0]        instr,
  input  wire  [cpu_pkg::data_w-1:0]        op_a,
  input  wire  [cpu_pkg::data_w-1:0]        op_b,
  input  wire  [cpu_pkg::data_w-1:0]        imm,
  input  wire  [cpu_pkg::reg_addr_w-1:0]    dest,
  input  wire  cpu_pkg::opcode_t            alu_op,
  input  wire                               use_imm,
  input  wire                               mem_rd,
  input  wire                               mem_wr,
  input  wire                               reg_wr,
  input  wire                               is_halt,
  input  wire  [cpu_pkg::data_w-1:0]        result,
  input  wire  [cpu_pkg::dmem_addr_w-1:0]   mem_addr,
  input  wire  [cpu_pkg::data_w-1:0]        rdata,
  output logic                              fetch_en,
  output logic                              exec_en,
  output logic                              mem_en,
  output logic [cpu_pkg::data_w-1:0]        ifid_instr,
  output logic [cpu_pkg::data_w-1:0]        idex_op_a,
  output logic [cpu_pkg::data_w-1:0]        idex_op_b,
  output logic [cpu_pkg::data_w-1:0]        idex_imm,
  output cpu_pkg::opcode_t                  idex_alu_op,
  output logic                              idex_use_imm,
  output logic [cpu_pkg::dmem_addr_w-1:0]   exmem_addr,
  output logic [cpu_pkg::data_w-1:0]        exmem_wdata,
  output logic                              exmem_mem_rd,
  output logic                              exmem_mem_wr,
  output logic                              wb_valid,
  output logic [cpu_pkg::reg_addr_w-1:0]    wb_addr,
  output logic [cpu_pkg::data_w-1:0]        wb_data,
  output logic                              halted
);

  cpu_pkg::state_t                  state;
  cpu_pkg::state_t                  next_state;
  logic                             start_q;
  logic                             decode_en;
  logic [cpu_pkg::imem_addr_w-1:0]  ifid_pc;
  logic [cpu_pkg::reg_addr_w-1:0]   idex_dest;
  logic                             idex_mem_rd;
  logic                             idex_mem_wr;
  logic                             idex_reg_wr;
  logic                             idex_halt;
  logic [cpu_pkg::data_w-1:0]       exmem_result;
  logic [cpu_pkg::reg_addr_w-1:0]   exmem_dest;
  logic                             exmem_reg_wr;
  logic                             exmem_halt;

  // the fetch is issued on the way into st_fetch
  assign fetch_en  = (state == cpu_pkg::st_idle && start_q) ||
                     state == cpu_pkg::st_write_back;
  assign decode_en = state == cpu_pkg::st_decode;
  assign exec_en   = state == cpu_pkg::st_execute;
  assign mem_en    = state == cpu_pkg::st_memory;
  assign halted    = state == cpu_pkg::st_halt;

  assign wb_valid = state == cpu_pkg::st_write_back && exmem_reg_wr;
  assign wb_addr  = exmem_dest;
  assign wb_data  = exmem_mem_rd ? rdata : exmem_result;  // load or ALU result

  always_comb
  begin
    next_state = state;
    case (state)
      cpu_pkg::st_idle:
        if (start_q)
          next_state = cpu_pkg::st_fetch;
      cpu_pkg::st_fetch:
        next_state = cpu_pkg::st_decode;
      cpu_pkg::st_decode:
        next_state = cpu_pkg::st_execute;
      cpu_pkg::st_execute:
        next_state = cpu_pkg::st_memory;
      cpu_pkg::st_memory:
        next_state = exmem_halt ? cpu_pkg::st_halt : cpu_pkg::st_write_back;
      cpu_pkg::st_write_back:
        next_state = cpu_pkg::st_fetch;
      cpu_pkg::st_halt:
        next_state = cpu_pkg::st_halt;  // left only by reset
      default:
        next_state = cpu_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state        <= cpu_pkg::st_idle;
      start_q      <= 1'b0;
      idex_mem_rd  <= 1'b0;
      idex_mem_wr  <= 1'b0;
      idex_reg_wr  <= 1'b0;
      idex_halt    <= 1'b0;
      exmem_mem_rd <= 1'b0;
      exmem_mem_wr <= 1'b0;
      exmem_reg_wr <= 1'b0;
      exmem_halt   <= 1'b0;
    end
    else
    begin
      state   <= next_state;
      start_q <= start;
      if (decode_en)
      begin
        idex_mem_rd <= mem_rd;
        idex_mem_wr <= mem_wr;
        idex_reg_wr <= reg_wr;
        idex_halt   <= is_halt;
      end
      if (exec_en)
      begin
        exmem_mem_rd <= idex_mem_rd;
        exmem_mem_wr <= idex_mem_wr;
        exmem_reg_wr <= idex_reg_wr;
        exmem_halt   <= idex_halt;
      end
    end
  end

  // stage payloads
  always_ff @(posedge clk)
  begin
    if (state == cpu_pkg::st_fetch)
    begin
      ifid_instr <= instr;
      ifid_pc    <= pc;  // already points past this instruction
    end
    if (decode_en)
    begin
      idex_op_a    <= op_a;
      idex_op_b    <= op_b;
      idex_imm     <= imm;
      idex_alu_op  <= alu_op;
      idex_use_imm <= use_imm;
      idex_dest    <= dest;
    end
    if (exec_en)
    begin
      exmem_result <= result;
      exmem_addr   <= mem_addr;
      exmem_wdata  <= idex_op_b;
      exmem_dest   <= idex_dest;
    end
  end

  a_wb_after_memory: assert property (@(posedge clk) disable iff (rst)
    wb_valid |-> state == cpu_pkg::st_write_back && $past(mem_en))
    else $error("wb_valid outside write back");

  // each fetch moves the pc on by exactly one word
  a_pc_step: assert property (@(posedge clk) disable iff (rst)
    decode_en |-> ifid_pc == (cpu_pkg::imem_addr_w)'($past(pc, 2) + 1'b1))
    else $error("pc did not advance by one word on a fetch");

endmodule

`default_nettype wire

//--- verilog/data_memory.sv
`timescale 1ns/10ps
`default_nettype none

module data_memory (
  input  wire                               clk,
  input  wire                               mem_en,
  input  wire                               mem_rd,
  input  wire                               mem_wr,
  input  wire  [cpu_pkg::dmem_addr_w-1:0]   addr,
  input  wire  [cpu_pkg::data_w-1:0]        wdata,
  output logic [cpu_pkg::data_w-1:0]        rdata
);

  logic [cpu_pkg::data_w-1:0] ram [cpu_pkg::dmem_depth];

  always_ff @(posedge clk)
  begin
    if (mem_en)
    begin
      if (mem_wr)
        ram[addr] <= wdata;
      if (mem_rd)
        rdata <= ram[addr];  // ready in write back
    end
  end

  // one instruction is either a load or a store, never both
  a_rd_wr_exclusive: assert property (@(posedge clk)
    mem_en |-> !(mem_rd && mem_wr))
    else $error("data memory read and write in the same access");

endmodule

`default_nettype wire

//--- verilog/alu_execute.sv
`timescale 1ns/10ps
`default_nettype none

module alu_execute (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               exec_en,
  input  wire  [cpu_pkg::data_w-1:0]        op_a,
  input  wire  [cpu_pkg::data_w-1:0]        op_b,
  input  wire  [cpu_pkg::data_w-1:0]        imm,
  input  wire  cpu_pkg::opcode_t            alu_op,
  input  wire                               use_imm,
  output logic [cpu_pkg::data_w-1:0]        result,
  output logic [cpu_pkg::dmem_addr_w-1:0]   mem_addr,
  output logic [cpu_pkg::ccr_w-1:0]         ccr
);

  logic [cpu_pkg::data_w-1:0] opnd_b;
  logic [cpu_pkg::data_w:0]   res_ext;  // extra top bit holds carry
  logic                       is_alu;

  assign opnd_b   = use_imm ? imm : op_b;
  assign mem_addr = op_a[cpu_pkg::dmem_addr_w-1:0];
  assign result   = res_ext[cpu_pkg::data_w-1:0];

  always_comb
  begin
    is_alu = 1'b1;
    case (alu_op)
      cpu_pkg::op_add:
        res_ext = {1'b0, op_a} + {1'b0, opnd_b};
      cpu_pkg::op_sub:
        res_ext = {1'b0, op_a} - {1'b0, opnd_b};  // top bit is the borrow
      cpu_pkg::op_and:
        res_ext = {1'b0, op_a & opnd_b};
      cpu_pkg::op_or:
        res_ext = {1'b0, op_a | opnd_b};
      cpu_pkg::op_xor:
        res_ext = {1'b0, op_a ^ opnd_b};
      cpu_pkg::op_ldm:
      begin
        res_ext = {1'b0, opnd_b};  // immediate passes through
        is_alu  = 1'b0;
      end
      default:
      begin
        res_ext = '0;
        is_alu  = 1'b0;
      end
    endcase
  end

  // flags only follow the five ALU opcodes
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      ccr <= '0;
    else if (exec_en && is_alu)
    begin
      ccr[cpu_pkg::ccr_z] <= (result == '0);
      ccr[cpu_pkg::ccr_n] <= result[cpu_pkg::data_w-1];
      ccr[cpu_pkg::ccr_c] <= res_ext[cpu_pkg::data_w];  // zero for logic ops
    end
  end

endmodule

`default_nettype wire

//--- verilog/decode_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module decode_regfile (
  input  wire                               clk,
  input  wire                               rst,
  input  wire  [cpu_pkg::data_w-1:0]        instr,
  input  wire                               wb_we,
  input  wire  [cpu_pkg::reg_addr_w-1:0]    wb_addr,
  input  wire  [cpu_pkg::data_w-1:0]        wb_data,
  output logic [cpu_pkg::data_w-1:0]        op_a,
  output logic [cpu_pkg::data_w-1:0]        op_b,
  output logic [cpu_pkg::data_w-1:0]        imm,
  output logic [cpu_pkg::reg_addr_w-1:0]    dest,
  output cpu_pkg::opcode_t                  alu_op,
  output logic                              use_imm,
  output logic                              mem_rd,
  output logic                              mem_wr,
  output logic                              reg_wr,
  output logic                              is_halt
);

  cpu_pkg::opcode_t                opcode;
  logic [cpu_pkg::reg_addr_w-1:0]  rs;
  logic [cpu_pkg::reg_addr_w-1:0]  rt;
  logic [cpu_pkg::data_w-1:0]      regs [cpu_pkg::num_regs];

  assign opcode = cpu_pkg::opcode_t'(instr[cpu_pkg::op_lsb +: cpu_pkg::op_w]);
  assign dest   = instr[cpu_pkg::rd_lsb +: cpu_pkg::reg_addr_w];
  assign rs     = instr[cpu_pkg::rs_lsb +: cpu_pkg::reg_addr_w];
  assign rt     = instr[cpu_pkg::rt_lsb +: cpu_pkg::reg_addr_w];
  assign imm    = {{(cpu_pkg::data_w - cpu_pkg::imm_w){1'b0}}, instr[cpu_pkg::imm_w-1:0]};

  assign op_a = regs[rs];
  assign op_b = regs[rt];  // also the store data

  always_comb
  begin
    alu_op  = opcode;
    use_imm = 1'b0;
    mem_rd  = 1'b0;
    mem_wr  = 1'b0;
    reg_wr  = 1'b0;
    is_halt = 1'b0;
    case (opcode)
      cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
      cpu_pkg::op_or, cpu_pkg::op_xor:
        reg_wr = 1'b1;
      cpu_pkg::op_ldm:
      begin
        reg_wr  = 1'b1;
        use_imm = 1'b1;
      end
      cpu_pkg::op_ld:
      begin
        reg_wr = 1'b1;
        mem_rd = 1'b1;
      end
      cpu_pkg::op_st:
        mem_wr = 1'b1;  // no write back
      cpu_pkg::op_halt:
        is_halt = 1'b1;
      cpu_pkg::op_nop:
        reg_wr = 1'b0;
      default:
        alu_op = cpu_pkg::op_nop;  // undefined codes run as nop
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < cpu_pkg::num_regs; i++)
        regs[i] <= '0;
    end
    else if (wb_we)
      regs[wb_addr] <= wb_data;  // end of write back
  end

  // the controller holds write back off during reset
  a_no_write_in_reset: assert property (@(posedge clk)
    rst |-> !wb_we)
    else $error("register write while in reset");

endmodule

`default_nettype wire

//--- verilog/instr_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module instr_fetch (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               fetch_en,
  input  wire                               prog_we,
  input  wire  [cpu_pkg::imem_addr_w-1:0]   prog_addr,
  input  wire  [cpu_pkg::data_w-1:0]        prog_data,
  output logic [cpu_pkg::data_w-1:0]        instr,
  output logic [cpu_pkg::imem_addr_w-1:0]   pc
);

  logic [cpu_pkg::data_w-1:0] imem [cpu_pkg::imem_depth];

  // load port and instruction read on the same clock
  always_ff @(posedge clk)
  begin
    if (prog_we)
      imem[prog_addr] <= prog_data;
    if (fetch_en)
      instr <= imem[pc];  // valid one cycle after fetch_en
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      pc <= '0;
    else if (fetch_en)
      pc <= pc + 1'b1;  // wraps at the end of memory
  end

  // the program is only loaded while the core sits idle
  a_no_load_in_fetch: assert property (@(posedge clk) disable iff (rst)
    !(prog_we && fetch_en))
    else $error("program write while an instruction is fetched");

endmodule

`default_nettype wire

//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int data_w      = 16;
  localparam int reg_addr_w  = 3;
  localparam int num_regs    = 8;
  localparam int imem_addr_w = 8;
  localparam int dmem_addr_w = 8;
  localparam int imem_depth  = 256;
  localparam int dmem_depth  = 256;

  // instruction word layout, opcode in the top bits
  localparam int op_w   = 5;
  localparam int imm_w  = 8;
  localparam int op_lsb = data_w - op_w;
  localparam int rd_lsb = op_lsb - reg_addr_w;
  localparam int rs_lsb = rd_lsb - reg_addr_w;
  localparam int rt_lsb = rs_lsb - reg_addr_w;

  localparam int ccr_w = 3;
  localparam int ccr_z = 0;  // zero
  localparam int ccr_n = 1;  // negative
  localparam int ccr_c = 2;  // carry, borrow on sub

  typedef enum logic [2:0] {
    st_idle       = 3'd0,
    st_fetch      = 3'd1,
    st_decode     = 3'd2,
    st_execute    = 3'd3,
    st_memory     = 3'd4,
    st_write_back = 3'd5,
    st_halt       = 3'd6
  } state_t;

  typedef enum logic [op_w-1:0] {
    op_nop  = 5'h00,
    op_add  = 5'h01,
    op_sub  = 5'h02,
    op_and  = 5'h03,
    op_or   = 5'h04,
    op_xor  = 5'h05,
    op_ldm  = 5'h10,
    op_ld   = 5'h11,
    op_st   = 5'h12,
    op_halt = 5'h1f
  } opcode_t;

endpackage

`default_nettype wire
